/* source/fpu_cfg.svh */
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Execution unit shape
`define FPU_LANES 2
`define FPU_TAGS 4
`define FPU_MAX_INFLIGHT 4
`define FPU_PIPE_DEPTH 3

// Register map, byte addresses on the 8-bit AXI4-Lite address bus
// The command word carries an fpu_cmd_t in its low bits: op in 6:4, lane mask in 3:2, tag in 1:0
`define FPU_ADDR_A0 8'h00
`define FPU_ADDR_A1 8'h04
`define FPU_ADDR_B0 8'h08
`define FPU_ADDR_B1 8'h0c
`define FPU_ADDR_CMD 8'h10
`define FPU_ADDR_STATUS 8'h14
`define FPU_ADDR_RESULT 8'h20

`endif

/* source/fpu_pkg.sv */
`default_nettype none

`include "fpu_cfg.svh"

package fpu_pkg;

	typedef enum logic [2:0]
	{
		OP_FADD = 3'd0,
		OP_FSUB = 3'd1,
		OP_FMUL = 3'd2,
		OP_FGTR = 3'd3,
		OP_FLT = 3'd4
	} fp_op_t;

	// One single-precision value per lane
	typedef logic [31:0] lane_word_t;

	typedef struct packed
	{
		fp_op_t op;
		logic [`FPU_LANES-1:0] mask;
		logic [1:0] tag;
	} fpu_cmd_t;

	// Output of the alignment stage, one per lane
	typedef struct packed
	{
		logic [7:0] add_exponent;
		logic [24:0] sig_large;
		logic [24:0] sig_small;
		logic logical_subtract;
		logic add_sign;
		// Product exponent is two's complement so underflow and overflow stay visible
		logic [9:0] mul_exponent;
		logic [47:0] product;
		logic mul_sign;
		logic is_inf;
		logic is_nan;
	} align_payload_t;

	// Output of the summation stage, one per lane
	typedef struct packed
	{
		logic [24:0] significand;
		logic [4:0] norm_shift;
		logic [7:0] add_exponent;
		logic add_sign;
		logic [9:0] mul_exponent;
		logic [47:0] product;
		logic mul_sign;
		logic is_inf;
		logic is_nan;
	} sum_payload_t;

endpackage

`default_nettype wire

/* source/fpu_stage_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

// Link between two pipeline stages
// There is no handshake since the pipeline never stalls
interface fpu_stage_if
	import fpu_pkg::*;
#(
	parameter type payload_t = logic
)
();
	logic valid;
	fpu_cmd_t cmd;
	payload_t [`FPU_LANES-1:0] payload;

	// The producing stage drives everything, the consuming stage only samples
	modport source (output valid, output cmd, output payload);
	modport sink (input valid, input cmd, input payload);
endinterface

`default_nettype wire

/* source/fpu_operand_align.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_operand_align
	import fpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic issue,
	input fpu_cmd_t issue_cmd,
	input lane_word_t [`FPU_LANES-1:0] op_a,
	input lane_word_t [`FPU_LANES-1:0] op_b,
	fpu_stage_if.source align
);
	logic flip_b;
	logic is_mul;
	align_payload_t [`FPU_LANES-1:0] next_payload;

	// Subtract and both compares work on a minus b
	assign flip_b = issue_cmd.op inside {OP_FSUB, OP_FGTR, OP_FLT};
	assign is_mul = issue_cmd.op == OP_FMUL;

	genvar lane;
	generate
		for (lane = 0; lane < `FPU_LANES; lane++)
		begin : lane_logic
			logic [7:0] exp_a;
			logic [7:0] exp_b;
			logic [22:0] frac_a;
			logic [22:0] frac_b;
			logic zero_a;
			logic zero_b;
			logic inf_a;
			logic inf_b;
			logic nan_a;
			logic nan_b;
			logic sign_a;
			logic sign_b;
			logic [23:0] sig_a;
			logic [23:0] sig_b;
			logic swap;
			logic sign_large;
			logic sign_small;
			logic [7:0] exp_large;
			logic [7:0] exp_small;
			logic [23:0] sig_large;
			logic [23:0] sig_small;
			logic logical_subtract;
			logic is_nan;
			logic is_inf;

			// Subnormal inputs are flushed, so a zero exponent also clears the fraction
			assign exp_a = op_a[lane][30:23];
			assign exp_b = op_b[lane][30:23];
			assign zero_a = exp_a == 8'd0;
			assign zero_b = exp_b == 8'd0;
			assign frac_a = zero_a ? 23'd0 : op_a[lane][22:0];
			assign frac_b = zero_b ? 23'd0 : op_b[lane][22:0];
			assign inf_a = exp_a == 8'hff && frac_a == 23'd0;
			assign inf_b = exp_b == 8'hff && frac_b == 23'd0;
			assign nan_a = exp_a == 8'hff && frac_a != 23'd0;
			assign nan_b = exp_b == 8'hff && frac_b != 23'd0;
			assign sig_a = {!zero_a, frac_a};
			assign sig_b = {!zero_b, frac_b};
			assign sign_a = op_a[lane][31];
			assign sign_b = op_b[lane][31] ^ flip_b;

			// Larger magnitude leads, ties keep a in front
			assign swap = {exp_b, frac_b} > {exp_a, frac_a};
			assign {sign_large, exp_large, sig_large} = swap ? {sign_b, exp_b, sig_b}
				: {sign_a, exp_a, sig_a};
			assign {sign_small, exp_small, sig_small} = swap ? {sign_a, exp_a, sig_a}
				: {sign_b, exp_b, sig_b};
			assign logical_subtract = sign_large != sign_small;

			always_comb
			begin
				// Infinity times zero has no meaningful value either
				if (is_mul)
					is_nan = nan_a || nan_b || (inf_a && zero_b) || (zero_a && inf_b);
				else
					is_nan = nan_a || nan_b || (inf_a && inf_b && logical_subtract);
				is_inf = (inf_a || inf_b) && !is_nan;
			end

			// Bit 24 is left free for the carry of the next stage
			assign next_payload[lane] = '{
				add_exponent: exp_large,
				sig_large: {1'b0, sig_large},
				sig_small: {1'b0, sig_small} >> (exp_large - exp_small),
				logical_subtract: logical_subtract,
				add_sign: sign_large,
				mul_exponent: {2'b00, exp_a} + {2'b00, exp_b} - 10'd127,
				product: sig_a * sig_b,
				mul_sign: sign_a ^ sign_b,
				is_inf: is_inf,
				is_nan: is_nan
			};
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			align.valid <= 1'b0;
			align.cmd <= '0;
		end
		else
		begin
			align.valid <= issue;
			align.cmd <= issue_cmd;
		end
	end

	always_ff @(posedge clk)
	begin
		align.payload <= next_payload;
	end
endmodule

`default_nettype wire

/* source/fpu_significand_sum.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_significand_sum
	import fpu_pkg::*;
(
	input logic clk,
	input logic reset,
	fpu_stage_if.sink align,
	fpu_stage_if.source sum
);
	sum_payload_t [`FPU_LANES-1:0] next_payload;

	// Position of the highest set bit counted from bit 24, so a carry gives 0
	// An all-zero sum gives 25
	function automatic logic [4:0] leading_zeros(input logic [24:0] value);
		logic [4:0] count;
		count = 5'd25;
		for (int i = 0; i < 25; i++)
		begin
			if (value[i])
				count = 5'(24 - i);
		end
		return count;
	endfunction

	genvar lane;
	generate
		for (lane = 0; lane < `FPU_LANES; lane++)
		begin : lane_logic
			logic [24:0] sum_value;

			// The larger operand leads, so the difference never goes negative
			assign sum_value = align.payload[lane].logical_subtract
				? align.payload[lane].sig_large - align.payload[lane].sig_small
				: align.payload[lane].sig_large + align.payload[lane].sig_small;

			// Product fields and special flags ride along unchanged
			assign next_payload[lane] = '{
				significand: sum_value,
				norm_shift: leading_zeros(sum_value),
				add_exponent: align.payload[lane].add_exponent,
				add_sign: align.payload[lane].add_sign,
				mul_exponent: align.payload[lane].mul_exponent,
				product: align.payload[lane].product,
				mul_sign: align.payload[lane].mul_sign,
				is_inf: align.payload[lane].is_inf,
				is_nan: align.payload[lane].is_nan
			};
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			sum.valid <= 1'b0;
			sum.cmd <= '0;
		end
		else
		begin
			sum.valid <= align.valid;
			sum.cmd <= align.cmd;
		end
	end

	always_ff @(posedge clk)
	begin
		sum.payload <= next_payload;
	end
endmodule

`default_nettype wire

/* source/fpu_normalize.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_normalize
	import fpu_pkg::*;
(
	input logic clk,
	input logic reset,
	fpu_stage_if.sink sum,
	output logic retire,
	output fpu_cmd_t retire_cmd,
	output lane_word_t [`FPU_LANES-1:0] lane_result
);
	lane_word_t [`FPU_LANES-1:0] next_result;

	genvar lane;
	generate
		for (lane = 0; lane < `FPU_LANES; lane++)
		begin : lane_logic
			sum_payload_t lane_in;
			logic sum_is_zero;
			logic carry;
			logic [24:0] shifted;
			logic [9:0] add_exp_norm;
			logic [32:0] add_packed;
			logic [31:0] add_result;
			logic mul_shift;
			logic [22:0] mul_frac;
			logic guard;
			logic round_bit;
			logic sticky;
			logic [9:0] mul_exp_norm;
			logic [32:0] mul_packed;
			logic [31:0] mul_result;
			logic compare_result;

			assign lane_in = sum.payload[lane];
			assign sum_is_zero = lane_in.significand == 25'd0;
			assign carry = lane_in.norm_shift == 5'd0;
			assign shifted = lane_in.significand << lane_in.norm_shift;
			assign add_exp_norm = {2'b00, lane_in.add_exponent} - {5'd0, lane_in.norm_shift} + 10'd1;

			// Exponent and fraction are packed together so a rounding carry moves into the exponent
			// On a carry the shifter is skipped and the dropped bit is added back
			assign add_packed = carry
				? {add_exp_norm, lane_in.significand[23:1]} + 33'(lane_in.significand[0])
				: {add_exp_norm, shifted[23:1]};

			always_comb
			begin
				if (lane_in.is_nan)
					add_result = 32'h7fffffff;
				else if (lane_in.is_inf)
					add_result = {lane_in.add_sign, 8'hff, 23'd0};
				else if (sum_is_zero)
					add_result = 32'd0;
				else if ($signed(add_packed[32:23]) <= 0)
					add_result = {lane_in.add_sign, 31'd0};
				else if ($signed(add_packed[32:23]) >= 255)
					add_result = {lane_in.add_sign, 8'hff, 23'd0};
				else
					add_result = {lane_in.add_sign, add_packed[30:0]};
			end

			// Both factors start with a leading one, so at most one place of shift is needed
			assign mul_shift = !lane_in.product[47];
			assign mul_frac = mul_shift ? lane_in.product[45:23] : lane_in.product[46:24];
			assign {guard, round_bit, sticky} = mul_shift
				? {lane_in.product[22:21], |lane_in.product[20:0]}
				: {lane_in.product[23:22], |lane_in.product[21:0]};
			assign mul_exp_norm = lane_in.mul_exponent + {9'd0, !mul_shift};
			assign mul_packed = {mul_exp_norm, mul_frac} + 33'(guard && (round_bit || sticky));

			always_comb
			begin
				if (lane_in.is_nan)
					mul_result = 32'h7fffffff;
				else if (lane_in.is_inf)
					mul_result = {lane_in.mul_sign, 8'hff, 23'd0};
				else if (lane_in.product == 48'd0 || $signed(mul_packed[32:23]) <= 0)
					mul_result = {lane_in.mul_sign, 31'd0};
				else if ($signed(mul_packed[32:23]) >= 255)
					mul_result = {lane_in.mul_sign, 8'hff, 23'd0};
				else
					mul_result = {lane_in.mul_sign, mul_packed[30:0]};
			end

			// Compares look at the sign of a minus b and whether it cancelled exactly
			always_comb
			begin
				compare_result = 1'b0;
				if (!lane_in.is_nan)
				begin
					case (sum.cmd.op)
						OP_FGTR: compare_result = !lane_in.add_sign && !sum_is_zero;
						OP_FLT: compare_result = lane_in.add_sign && !sum_is_zero;
						default: compare_result = 1'b0;
					endcase
				end
			end

			always_comb
			begin
				case (sum.cmd.op)
					OP_FMUL: next_result[lane] = mul_result;
					OP_FGTR, OP_FLT: next_result[lane] = {31'd0, compare_result};
					default: next_result[lane] = add_result;
				endcase
			end
		end
	endgenerate

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			retire <= 1'b0;
			retire_cmd <= '0;
		end
		else
		begin
			retire <= sum.valid;
			retire_cmd <= sum.cmd;
		end
	end

	always_ff @(posedge clk)
	begin
		lane_result <= next_result;
	end
endmodule

`default_nettype wire

/* source/fpu_inflight_counter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_inflight_counter
(
	input logic clk,
	input logic reset,
	input logic issue,
	input logic retire,
	output logic full,
	output logic [2:0] count
);
	// Issue and retire in the same cycle cancel out
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			count <= 3'd0;
		else if (issue && !retire)
			count <= count + 3'd1;
		else if (retire && !issue)
			count <= count - 3'd1;
	end

	// The host holds off further commands at the limit
	assign full = count == `FPU_MAX_INFLIGHT;
endmodule

`default_nettype wire

/* source/fpu_host_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_host_fsm
	import fpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [7:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [7:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready,
	output logic issue,
	output fpu_cmd_t issue_cmd,
	output lane_word_t [`FPU_LANES-1:0] op_a,
	output lane_word_t [`FPU_LANES-1:0] op_b,
	input logic full,
	input logic [2:0] count,
	input logic retire,
	input fpu_cmd_t retire_cmd,
	input lane_word_t [`FPU_LANES-1:0] lane_result
);
	typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;
	typedef enum logic {RD_IDLE, RD_DATA} rd_state_t;

	wr_state_t wr_state;
	rd_state_t rd_state;
	lane_word_t [`FPU_LANES-1:0] a_reg;
	lane_word_t [`FPU_LANES-1:0] b_reg;
	logic [`FPU_TAGS-1:0] done;
	lane_word_t result_bank [`FPU_TAGS * `FPU_LANES];
	logic write_is_cmd;
	logic write_accept;
	logic read_accept;
	logic [7:0] result_offset;
	lane_word_t status_word;
	lane_word_t read_value;

	// Address and data are taken together, and a command waits while the pipe is full
	assign write_is_cmd = s_awaddr == `FPU_ADDR_CMD;
	assign write_accept = wr_state == WR_IDLE && s_awvalid && s_wvalid && !(write_is_cmd && full);
	assign s_awready = write_accept;
	assign s_wready = write_accept;
	assign s_bvalid = wr_state == WR_RESP;
	assign s_bresp = 2'b00;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			wr_state <= WR_IDLE;
			issue <= 1'b0;
			issue_cmd <= '0;
		end
		else
		begin
			issue <= write_accept && write_is_cmd;
			if (write_accept && write_is_cmd)
				issue_cmd <= fpu_cmd_t'(s_wdata[$bits(fpu_cmd_t)-1:0]);
			case (wr_state)
				WR_IDLE: if (write_accept) wr_state <= WR_RESP;
				WR_RESP: if (s_bready) wr_state <= WR_IDLE;
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	// Operand registers, and the snapshot handed to the pipe with the command
	always_ff @(posedge clk)
	begin
		if (write_accept)
		begin
			case (s_awaddr)
				`FPU_ADDR_A0: a_reg[0] <= s_wdata;
				`FPU_ADDR_A1: a_reg[1] <= s_wdata;
				`FPU_ADDR_B0: b_reg[0] <= s_wdata;
				`FPU_ADDR_B1: b_reg[1] <= s_wdata;
				`FPU_ADDR_CMD:
				begin
					op_a <= a_reg;
					op_b <= b_reg;
				end
				default: ;
			endcase
		end
	end

	// A reissued tag clears its done bit even if an older one retires in the same cycle
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			done <= '0;
		else
		begin
			if (retire)
				done[retire_cmd.tag] <= 1'b1;
			if (issue)
				done[issue_cmd.tag] <= 1'b0;
		end
	end

	// Lanes outside the mask keep whatever the slot held
	always_ff @(posedge clk)
	begin
		if (retire)
		begin
			for (int lane = 0; lane < `FPU_LANES; lane++)
			begin
				if (retire_cmd.mask[lane])
					result_bank[int'(retire_cmd.tag) * `FPU_LANES + lane] <= lane_result[lane];
			end
		end
	end

	assign read_accept = rd_state == RD_IDLE && s_arvalid;
	assign s_arready = read_accept;
	assign s_rvalid = rd_state == RD_DATA;
	assign s_rresp = 2'b00;
	assign result_offset = s_araddr - `FPU_ADDR_RESULT;

	always_comb
	begin
		status_word = '0;
		status_word[2:0] = count;
		status_word[8 +: `FPU_TAGS] = done;
	end

	always_comb
	begin
		case (s_araddr)
			`FPU_ADDR_A0: read_value = a_reg[0];
			`FPU_ADDR_A1: read_value = a_reg[1];
			`FPU_ADDR_B0: read_value = b_reg[0];
			`FPU_ADDR_B1: read_value = b_reg[1];
			`FPU_ADDR_STATUS: read_value = status_word;
			default:
			begin
				// Result slots are word addressed from the bank base
				if (s_araddr >= `FPU_ADDR_RESULT && result_offset < 4 * `FPU_TAGS * `FPU_LANES)
					read_value = result_bank[result_offset[4:2]];
				else
					read_value = '0;
			end
		endcase
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			rd_state <= RD_IDLE;
		else
		begin
			case (rd_state)
				RD_IDLE: if (read_accept) rd_state <= RD_DATA;
				RD_DATA: if (s_rready) rd_state <= RD_IDLE;
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (read_accept)
			s_rdata <= read_value;
	end
endmodule

`default_nettype wire

/* source/fpu_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_top
	import fpu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [7:0] s_awaddr,
	input logic s_awvalid,
	output logic s_awready,
	input logic [31:0] s_wdata,
	input logic s_wvalid,
	output logic s_wready,
	output logic [1:0] s_bresp,
	output logic s_bvalid,
	input logic s_bready,
	input logic [7:0] s_araddr,
	input logic s_arvalid,
	output logic s_arready,
	output logic [31:0] s_rdata,
	output logic [1:0] s_rresp,
	output logic s_rvalid,
	input logic s_rready
);
	logic issue;
	logic retire;
	logic full;
	logic [2:0] count;
	fpu_cmd_t issue_cmd;
	fpu_cmd_t retire_cmd;
	lane_word_t [`FPU_LANES-1:0] op_a;
	lane_word_t [`FPU_LANES-1:0] op_b;
	lane_word_t [`FPU_LANES-1:0] lane_result;

	// One link type per stage boundary
	fpu_stage_if #(.payload_t(align_payload_t)) align_link ();
	fpu_stage_if #(.payload_t(sum_payload_t)) sum_link ();

	// Register port, result bank and command issue
	fpu_host_fsm host_fsm_i (.*);

	fpu_inflight_counter inflight_counter_i (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.retire(retire),
		.full(full),
		.count(count)
	);

	// Three-stage pipe, issue to retire in three cycles
	fpu_operand_align operand_align_i (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_cmd(issue_cmd),
		.op_a(op_a),
		.op_b(op_b),
		.align(align_link.source)
	);

	fpu_significand_sum significand_sum_i (
		.clk(clk),
		.reset(reset),
		.align(align_link.sink),
		.sum(sum_link.source)
	);

	fpu_normalize normalize_i (
		.clk(clk),
		.reset(reset),
		.sum(sum_link.sink),
		.retire(retire),
		.retire_cmd(retire_cmd),
		.lane_result(lane_result)
	);
endmodule

`default_nettype wire

/* verification/fpu_tb_tasks.svh */
`ifndef FPU_TB_TASKS_SVH
`define FPU_TB_TASKS_SVH

// One full-word AXI4-Lite write, address and data offered together
task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
	@(posedge clk);
	awaddr <= addr;
	wdata <= data;
	awvalid <= 1'b1;
	wvalid <= 1'b1;
	// Ready is combinational, so it is looked at on the falling edge
	do
		@(negedge clk);
	while (!awready);
	// Address and data are taken in the same cycle
	if (wready !== awready)
	begin
		errors++;
		$display("FAIL at %0t: wready %b does not match awready %b", $time, wready, awready);
	end
	@(posedge clk);
	awvalid <= 1'b0;
	wvalid <= 1'b0;
	bready <= 1'b1;
	do
		@(negedge clk);
	while (!bvalid);
	if (bresp !== 2'b00)
	begin
		errors++;
		$display("FAIL at %0t: write to %h answered with bresp %b", $time, addr, bresp);
	end
	@(posedge clk);
	bready <= 1'b0;
endtask

task automatic read_word(input logic [7:0] addr, output logic [31:0] data);
	@(posedge clk);
	araddr <= addr;
	arvalid <= 1'b1;
	do
		@(negedge clk);
	while (!arready);
	@(posedge clk);
	arvalid <= 1'b0;
	rready <= 1'b1;
	do
		@(negedge clk);
	while (!rvalid);
	data = rdata;
	if (rresp !== 2'b00)
	begin
		errors++;
		$display("FAIL at %0t: read of %h answered with rresp %b", $time, addr, rresp);
	end
	@(posedge clk);
	rready <= 1'b0;
endtask

// Expected lane result, worked out from the operation rules of the unit
function automatic logic [31:0] fpu_model(input fp_op_t op, input logic [31:0] a,
	input logic [31:0] b);
	logic [7:0] ea;
	logic [7:0] eb;
	logic [22:0] fa;
	logic [22:0] fb;
	logic sa;
	logic sb;
	logic za;
	logic zb;
	logic ia;
	logic ib;
	logic na;
	logic nb;
	logic [23:0] ma;
	logic [23:0] mb;
	logic sl;
	int el;
	int es;
	logic [24:0] ml;
	logic [24:0] msm;
	logic [24:0] total;
	logic [24:0] shifted;
	int lz;
	longint pk;
	longint exp_v;
	logic [47:0] prod;
	logic g;
	logic r;
	logic st;
	logic [22:0] frac;
	logic is_cmp;

	is_cmp = op == OP_FGTR || op == OP_FLT;
	ea = a[30:23];
	eb = b[30:23];
	za = ea == 8'd0;
	zb = eb == 8'd0;
	// Subnormals count as zero
	fa = za ? 23'd0 : a[22:0];
	fb = zb ? 23'd0 : b[22:0];
	ia = ea == 8'hff && fa == 23'd0;
	ib = eb == 8'hff && fb == 23'd0;
	na = ea == 8'hff && fa != 23'd0;
	nb = eb == 8'hff && fb != 23'd0;
	ma = {!za, fa};
	mb = {!zb, fb};
	sa = a[31];
	sb = b[31] ^ (op == OP_FSUB || is_cmp);

	if (op == OP_FMUL)
	begin
		if (na || nb || (ia && zb) || (za && ib))
			return 32'h7fffffff;
		if (ia || ib)
			return {sa ^ sb, 8'hff, 23'd0};
		prod = 48'(ma) * 48'(mb);
		if (prod == 48'd0)
			return {sa ^ sb, 31'd0};
		exp_v = longint'(ea) + longint'(eb) - 127;
		if (prod[47])
		begin
			frac = prod[46:24];
			g = prod[23];
			r = prod[22];
			st = |prod[21:0];
			exp_v = exp_v + 1;
		end
		else
		begin
			frac = prod[45:23];
			g = prod[22];
			r = prod[21];
			st = |prod[20:0];
		end
		// Rounding may carry out of the fraction into the exponent
		pk = exp_v * (longint'(1) << 23) + longint'(frac) + longint'(g && (r || st));
		exp_v = pk >>> 23;
		if (exp_v <= 0)
			return {sa ^ sb, 31'd0};
		if (exp_v >= 255)
			return {sa ^ sb, 8'hff, 23'd0};
		return {sa ^ sb, 8'(exp_v), 23'(pk)};
	end

	// Add, subtract and compare all go through the aligned sum of a and b
	if (na || nb || (ia && ib && sa != sb))
		return is_cmp ? 32'd0 : 32'h7fffffff;
	if ({ea, fa} >= {eb, fb})
	begin
		sl = sa;
		el = ea;
		es = eb;
		ml = {1'b0, ma};
		msm = {1'b0, mb};
	end
	else
	begin
		sl = sb;
		el = eb;
		es = ea;
		ml = {1'b0, mb};
		msm = {1'b0, ma};
	end
	msm = (el - es >= 25) ? 25'd0 : msm >> (el - es);
	total = (sa != sb) ? ml - msm : ml + msm;
	if (is_cmp)
		return {31'd0, (op == OP_FGTR) ? (!sl && total != 0) : (sl && total != 0)};
	if (ia || ib)
		return {sl, 8'hff, 23'd0};
	if (total == 25'd0)
		return 32'd0;
	lz = 0;
	for (int i = 0; i < 25; i++)
	begin
		if (total[i])
			lz = 24 - i;
	end
	shifted = total << lz;
	if (lz == 0)
		pk = longint'(el + 1) * (longint'(1) << 23) + total[23:1] + total[0];
	else
		pk = longint'(el - lz + 1) * (longint'(1) << 23) + shifted[23:1];
	exp_v = pk >>> 23;
	if (exp_v <= 0)
		return {sl, 31'd0};
	if (exp_v >= 255)
		return {sl, 8'hff, 23'd0};
	return {sl, 8'(exp_v), 23'(pk)};
endfunction

`endif

/* verification/fpu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_tb
	import fpu_pkg::*;
();
	localparam int CYCLE_LIMIT = 20000;

	logic clk;
	logic reset;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	// Expected contents of every result slot, known once a lane has been written
	logic [31:0] slot_exp [`FPU_TAGS * `FPU_LANES];
	logic slot_known [`FPU_TAGS * `FPU_LANES];
	logic [31:0] cmp_got;
	logic [31:0] cmp_exp;
	string cmp_what;
	event compare_ev;
	int checks;
	int errors;
	int test_errors;
	int cycle_count;
	int retire_seen;

	`include "fpu_tb_tasks.svh"

	fpu_top fpu_top_i (
		.clk(clk),
		.reset(reset),
		.s_awaddr(awaddr),
		.s_awvalid(awvalid),
		.s_awready(awready),
		.s_wdata(wdata),
		.s_wvalid(wvalid),
		.s_wready(wready),
		.s_bresp(bresp),
		.s_bvalid(bvalid),
		.s_bready(bready),
		.s_araddr(araddr),
		.s_arvalid(arvalid),
		.s_arready(arready),
		.s_rdata(rdata),
		.s_rresp(rresp),
		.s_rvalid(rvalid),
		.s_rready(rready)
	);

	always #10 clk = !clk;

	// Compares each slot read against the model value
	always @(compare_ev)
	begin
		if (cmp_got !== cmp_exp)
		begin
			errors++;
			$display("FAIL at %0t: %s read %h, expected %h", $time, cmp_what, cmp_got, cmp_exp);
		end
		checks++;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Retire counting for the back-pressure test
	always @(posedge clk)
	begin
		if (reset)
			retire_seen <= 0;
		else if (fpu_top_i.retire)
			retire_seen <= retire_seen + 1;
	end

	function automatic logic [31:0] random_normal();
		logic [7:0] exponent;
		exponent = 8'(64 + $urandom % 127);
		return {1'($urandom), exponent, 23'($urandom)};
	endfunction

	task automatic issue_cmd(input fp_op_t op, input logic [1:0] mask, input logic [1:0] tag,
		input logic [31:0] a0, input logic [31:0] a1, input logic [31:0] b0,
		input logic [31:0] b1);
		write_word(`FPU_ADDR_A0, a0);
		write_word(`FPU_ADDR_A1, a1);
		write_word(`FPU_ADDR_B0, b0);
		write_word(`FPU_ADDR_B1, b1);
		write_word(`FPU_ADDR_CMD, {25'd0, op, mask, tag});
		if (mask[0])
		begin
			slot_exp[tag * 2] = fpu_model(op, a0, b0);
			slot_known[tag * 2] = 1'b1;
		end
		if (mask[1])
		begin
			slot_exp[tag * 2 + 1] = fpu_model(op, a1, b1);
			slot_known[tag * 2 + 1] = 1'b1;
		end
	endtask

	task automatic wait_done(input logic [1:0] tag);
		logic [31:0] status;
		logic seen;
		seen = 1'b0;
		for (int poll = 0; poll < 40 && !seen; poll++)
		begin
			read_word(`FPU_ADDR_STATUS, status);
			seen = status[8 + tag];
		end
		if (!seen)
		begin
			errors++;
			$display("Tag %0d never reported done at %0t", tag, $time);
		end
	endtask

	task automatic check_slots(input logic [1:0] tag, input string what);
		logic [31:0] value;
		int checks_before;
		for (int lane = 0; lane < `FPU_LANES; lane++)
		begin
			read_word(8'(`FPU_ADDR_RESULT + 4 * (tag * `FPU_LANES + lane)), value);
			if (slot_known[tag * 2 + lane])
			begin
				cmp_got = value;
				cmp_exp = slot_exp[tag * 2 + lane];
				cmp_what = $sformatf("%s tag %0d lane %0d", what, tag, lane);
				checks_before = checks;
				-> compare_ev;
				// The comparing process counts a check once it has finished with it
				wait (checks == checks_before + 1);
			end
		end
	endtask

	task automatic run_cmd(input fp_op_t op, input logic [1:0] mask, input logic [1:0] tag,
		input logic [31:0] a0, input logic [31:0] a1, input logic [31:0] b0,
		input logic [31:0] b1, input string what);
		issue_cmd(op, mask, tag, a0, a1, b0, b1);
		wait_done(tag);
		check_slots(tag, what);
	endtask

	task automatic end_test(input string name);
		$display("Test %s: %s (%0d errors)", name, (errors == test_errors) ? "passed" : "failed",
			errors - test_errors);
		test_errors = errors;
	endtask

	initial
	begin
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] b0;
		logic [31:0] b1;
		logic [31:0] status;
		fp_op_t op;
		logic finished;
		int retire_base;

		clk = 1'b0;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		checks = 0;
		errors = 0;
		test_errors = 0;
		cycle_count = 0;
		void'($urandom(64341));
		for (int i = 0; i < `FPU_TAGS * `FPU_LANES; i++)
			slot_known[i] = 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;

		// Every fifth pair cancels exactly in both lanes, alternating add and subtract
		for (int n = 0; n < 200; n++)
		begin
			op = (n % 2) ? OP_FSUB : OP_FADD;
			a0 = random_normal();
			a1 = random_normal();
			b0 = random_normal();
			b1 = random_normal();
			if (n % 5 == 0)
			begin
				b0 = (op == OP_FSUB) ? a0 : {!a0[31], a0[30:0]};
				b1 = (op == OP_FSUB) ? a1 : {!a1[31], a1[30:0]};
			end
			run_cmd(op, 2'b11, 2'(n), a0, a1, b0, b1, "add/sub");
		end
		end_test("1 add and subtract");

		for (int n = 0; n < 200; n++)
			run_cmd(OP_FMUL, 2'b11, 2'(n), random_normal(), random_normal(), random_normal(),
				random_normal(), "multiply");
		end_test("2 multiply");

		for (int n = 0; n < 24; n++)
		begin
			op = (n % 2) ? OP_FLT : OP_FGTR;
			a0 = random_normal();
			b0 = random_normal();
			a1 = random_normal();
			b1 = (n % 3 == 0) ? a1 : random_normal();
			if (n % 4 == 1)
			begin
				a0 = 32'h00000000;
				b0 = 32'h80000000;
			end
			run_cmd(op, 2'b11, 2'(n), a0, a1, b0, b1, "compare");
		end
		end_test("3 compare");

		run_cmd(OP_FADD, 2'b11, 2'd0, 32'h7f800000, 32'hff800000, 32'h3f800000,
			32'h40000000, "inf add");
		run_cmd(OP_FMUL, 2'b11, 2'd1, 32'hff800000, 32'h7f800000, 32'h40000000,
			32'h00000000, "inf mul");
		run_cmd(OP_FSUB, 2'b11, 2'd2, 32'h7f800000, 32'h7fc00000, 32'h7f800000,
			32'h3f800000, "inf minus inf");
		run_cmd(OP_FADD, 2'b11, 2'd3, 32'h00400000, 32'h3f800000, 32'h3f800000,
			32'h80000001, "subnormal add");
		run_cmd(OP_FMUL, 2'b11, 2'd0, 32'h007fffff, 32'h3fc00000, 32'h40000000,
			32'h7f800001, "subnormal mul");
		end_test("4 special values");

		// Five commands without waiting, the fifth reuses tag 0
		retire_base = retire_seen;
		for (int k = 0; k < 5; k++)
		begin
			issue_cmd(OP_FADD, 2'b11, 2'(k), random_normal(), random_normal(), random_normal(),
				random_normal());
		end
		if (retire_seen - retire_base < 1)
		begin
			errors++;
			$display("FAIL at %0t: fifth command answered before any retire", $time);
		end
		finished = 1'b0;
		for (int poll = 0; poll < 40 && !finished; poll++)
		begin
			read_word(`FPU_ADDR_STATUS, status);
			finished = status[11:8] == 4'hf && status[2:0] == 3'd0;
		end
		if (!finished)
		begin
			errors++;
			$display("FAIL at %0t: status %h never showed all tags done and count 0", $time,
				status);
		end
		if (retire_seen - retire_base != 5)
		begin
			errors++;
			$display("FAIL at %0t: %0d commands retired, expected 5", $time,
				retire_seen - retire_base);
		end
		for (int t = 0; t < `FPU_TAGS; t++)
			check_slots(2'(t), "back-to-back");
		end_test("5 back-to-back");

		run_cmd(OP_FMUL, 2'b11, 2'd2, random_normal(), random_normal(), random_normal(),
			random_normal(), "mask setup");
		run_cmd(OP_FADD, 2'b01, 2'd2, random_normal(), random_normal(), random_normal(),
			random_normal(), "masked lane");
		end_test("6 lane mask");

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end
endmodule

`default_nettype wire

/* verification/fpu_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_assertions
(
	input logic clk,
	input logic reset,
	input logic [7:0] s_awaddr,
	input logic s_awvalid,
	input logic s_awready,
	input logic s_bvalid,
	input logic s_bready,
	input logic s_rvalid,
	input logic s_rready,
	input logic full,
	input logic [2:0] count
);
	// The in-flight count stays within the limit
	count_limit: assert property (@(posedge clk) disable iff (reset)
		count <= `FPU_MAX_INFLIGHT)
		else $error("in-flight count above limit");

	// A command handshake never completes while the pipe is full
	no_cmd_when_full: assert property (@(posedge clk) disable iff (reset)
		!(s_awvalid && s_awready && s_awaddr == `FPU_ADDR_CMD && full))
		else $error("command accepted while full");

	bvalid_holds: assert property (@(posedge clk) disable iff (reset)
		s_bvalid && !s_bready |=> s_bvalid)
		else $error("bvalid dropped before bready");

	rvalid_holds: assert property (@(posedge clk) disable iff (reset)
		s_rvalid && !s_rready |=> s_rvalid)
		else $error("rvalid dropped before rready");
endmodule

bind fpu_top fpu_assertions assertions_i (
	.clk(clk),
	.reset(reset),
	.s_awaddr(s_awaddr),
	.s_awvalid(s_awvalid),
	.s_awready(s_awready),
	.s_bvalid(s_bvalid),
	.s_bready(s_bready),
	.s_rvalid(s_rvalid),
	.s_rready(s_rready),
	.full(full),
	.count(count)
);

`default_nettype wire

/* project.f */
+incdir+source
+incdir+verification
source/fpu_pkg.sv
source/fpu_stage_if.sv
source/fpu_operand_align.sv
source/fpu_significand_sum.sv
source/fpu_normalize.sv
source/fpu_inflight_counter.sv
source/fpu_host_fsm.sv
source/fpu_top.sv
verification/fpu_tb.sv
verification/fpu_assertions.sv
